/* bench/cache_maint_tb.sv */
`timescale 1ns/1ps

module cache_maint_tb;
    import cache_maint_pkg::*;

    localparam int CYCLE_LIMIT = 4000;
    localparam logic [31:0] ERR_ADDR = 32'h0BAD_0010;
    localparam logic [5:0] LW_OPCODE = 6'b100011;

    logic Clk, aresetn;
    logic i_cmd_valid, o_cmd_ready;
    logic [31:0] i_instr, i_addr, i_taglo, i_data;
    cache_sel_t i_lookup_sel;
    logic [31:0] i_lookup_addr, o_lookup_data;
    logic o_lookup_hit, o_lookup_dirty;
    logic o_awvalid, i_awready, o_wvalid, i_wready, i_bvalid, o_bready, o_done;
    logic [31:0] o_awaddr, o_wdata;
    logic [1:0] i_bresp;
    cmd_status_t o_status;

    int errors = 0;
    int cycles = 0;
    int writes_seen = 0;
    int writes_expected = 0;
    logic [31:0] lfsr_q = 32'd68252;
    logic got_aw, got_w, b_hs;
    logic [31:0] aw_addr_q, w_data_q;

    // Scoreboard copy of both stores, index 0 is the I-cache
    logic [TAG_WIDTH-1:0] m_tag [2][SET_COUNT];
    logic [31:0] m_data [2][SET_COUNT];
    logic m_valid [2][SET_COUNT];
    logic m_dirty [2][SET_COUNT];
    logic [1:0] exp_status [$];
    logic [31:0] exp_wr_addr [$];
    logic [31:0] exp_wr_data [$];

    tb_clock_gen clk_gen_i (.Clk(Clk), .aresetn(aresetn));

    cache_maint_top cache_maint_top_i (.*);

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return lfsr_q[31];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_instr(input logic [2:0] op, input logic [1:0] sel);
        return {CACHE_OPCODE, 5'd4, op, sel, 16'h0040};
    endfunction

    always @(posedge Clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // AXI4-Lite memory model with random ready throttling
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge Clk) begin
        if (o_awvalid && i_awready) begin
            got_aw = 1'b1;
            aw_addr_q = o_awaddr;
        end
        if (o_wvalid && i_wready) begin
            got_w = 1'b1;
            w_data_q = o_wdata;
        end
        b_hs = i_bvalid && o_bready;
    end

    always @(negedge Clk) begin
        if (!aresetn) begin
            got_aw = 1'b0;
            got_w = 1'b0;
            b_hs = 1'b0;
        end else begin
            i_awready = rand_bit();
            i_wready = rand_bit() | rand_bit();
            if (b_hs) begin
                i_bvalid = 1'b0;
                b_hs = 1'b0;
            end
            if (got_aw && got_w && !i_bvalid) begin
                writes_seen++;
                if (exp_wr_addr.size() == 0) begin
                    $display("Unexpected write to address %h", aw_addr_q);
                    errors++;
                end else begin
                    assert (aw_addr_q == exp_wr_addr[0]) else begin
                        $display("MISMATCH o_awaddr: got %h expected %h", aw_addr_q,
                                 exp_wr_addr[0]);
                        errors++;
                    end
                    assert (w_data_q == exp_wr_data[0]) else begin
                        $display("MISMATCH o_wdata: got %h expected %h", w_data_q,
                                 exp_wr_data[0]);
                        errors++;
                    end
                    void'(exp_wr_addr.pop_front());
                    void'(exp_wr_data.pop_front());
                end
                i_bvalid = 1'b1;
                i_bresp = (aw_addr_q == ERR_ADDR) ? 2'b10 : 2'b00;
                got_aw = 1'b0;
                got_w = 1'b0;
            end
        end
    end

    // Completions in issue order
    always @(posedge Clk) begin
        if (o_done) begin
            if (exp_status.size() == 0) begin
                $display("Completion seen with no command outstanding");
                errors++;
            end else begin
                assert (o_status == exp_status[0]) else begin
                    $display("MISMATCH o_status: got %h expected %h", o_status, exp_status[0]);
                    errors++;
                end
                void'(exp_status.pop_front());
            end
        end
    end

    a_aw_held: assert property (@(posedge Clk) disable iff (!aresetn)
        o_awvalid && !i_awready |=> o_awvalid && $stable(o_awaddr))
        else begin
            $display("AW channel dropped or changed before it was accepted");
            errors++;
        end
    a_w_held: assert property (@(posedge Clk) disable iff (!aresetn)
        o_wvalid && !i_wready |=> o_wvalid && $stable(o_wdata))
        else begin
            $display("W channel dropped or changed before it was accepted");
            errors++;
        end

    // Applies one accepted command to the scoreboard
    task automatic record_cmd(input logic [31:0] instr, addr, taglo, data);
        logic [2:0] op;
        logic c;
        logic [3:0] idx;
        logic hit;
        logic wr;
        logic [31:0] wa;
        logic [1:0] st;
        op = instr[20:18];
        c = instr[16];
        idx = addr[5:2];
        hit = m_valid[c][idx] && m_tag[c][idx] == addr[31:6];
        wr = 1'b0;
        wa = {m_tag[c][idx], idx, 2'b00};
        st = ST_OK;
        if (instr[31:26] != CACHE_OPCODE) begin
            st = ST_ILLEGAL;
        end else if (instr[17] == 1'b0) begin
            case (op)
                3'd2: begin
                    m_tag[c][idx] = taglo[31:6];
                    m_valid[c][idx] = taglo[1];
                    m_dirty[c][idx] = c & taglo[0];
                end
                3'd3: begin
                    m_data[c][idx] = data;
                    if (m_valid[c][idx] && c) m_dirty[c][idx] = 1'b1;
                end
                3'd0: begin
                    wr = c && m_valid[c][idx] && m_dirty[c][idx];
                    m_valid[c][idx] = 1'b0;
                    m_dirty[c][idx] = 1'b0;
                end
                3'd4, 3'd5: begin
                    if (hit && (op == 3'd4 || c)) begin
                        wr = (op == 3'd5) && m_dirty[c][idx];
                        m_valid[c][idx] = 1'b0;
                        m_dirty[c][idx] = 1'b0;
                    end
                end
                default: begin
                end
            endcase
        end
        if (wr) begin
            exp_wr_addr.push_back(wa);
            exp_wr_data.push_back(m_data[c][idx]);
            writes_expected++;
            st = (wa == ERR_ADDR) ? ST_BUS_ERROR : ST_WRITEBACK;
        end
        exp_status.push_back(st);
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_cmd(input logic [31:0] instr, addr, taglo, data);
        i_cmd_valid = 1'b1;
        i_instr = instr;
        i_addr = addr;
        i_taglo = taglo;
        i_data = data;
        while (!o_cmd_ready) @(negedge Clk);
        record_cmd(instr, addr, taglo, data);
        @(negedge Clk);
        i_cmd_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_status.size() != 0) @(negedge Clk);
        @(negedge Clk);
    endtask

    task automatic check_lookup(input logic c, input logic [31:0] addr);
        logic eh;
        i_lookup_sel = cache_sel_t'({1'b0, c});
        i_lookup_addr = addr;
        #1;
        eh = m_valid[c][addr[5:2]] && m_tag[c][addr[5:2]] == addr[31:6];
        assert (o_lookup_hit == eh) else begin
            $display("MISMATCH o_lookup_hit: got %h expected %h", o_lookup_hit, eh);
            errors++;
        end
        assert (o_lookup_dirty == (eh && m_dirty[c][addr[5:2]])) else begin
            $display("MISMATCH o_lookup_dirty: got %h expected %h", o_lookup_dirty,
                     eh && m_dirty[c][addr[5:2]]);
            errors++;
        end
        if (eh) begin
            assert (o_lookup_data == m_data[c][addr[5:2]]) else begin
                $display("MISMATCH o_lookup_data: got %h expected %h", o_lookup_data,
                         m_data[c][addr[5:2]]);
                errors++;
            end
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [2:0] op_tbl [8];
        logic [1:0] tag_lo;
        logic [3:0] set_idx;
        logic [2:0] op_idx;
        logic sel_bit;
        logic tag_valid;
        logic tag_dirty;
        logic [31:0] wdata;
        op_tbl = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd5, 3'd2, 3'd3, 3'd5};
        for (int c = 0; c < 2; c++) begin
            for (int s = 0; s < SET_COUNT; s++) begin
                m_valid[c][s] = 1'b0;
                m_dirty[c][s] = 1'b0;
            end
        end
        i_cmd_valid = 1'b0;
        i_instr = '0;
        i_addr = '0;
        i_taglo = '0;
        i_data = '0;
        i_lookup_sel = SEL_ICACHE;
        i_lookup_addr = '0;
        i_awready = 1'b0;
        i_wready = 1'b0;
        i_bvalid = 1'b0;
        i_bresp = 2'b00;

        // Reset hold with all control outputs quiet
        @(posedge aresetn);
        repeat (RESET_HOLD_CYCLES) begin
            @(negedge Clk);
            assert (!(o_cmd_ready || o_done || o_awvalid || o_wvalid || o_bready)) else begin
                $display("Control output high during reset hold");
                errors++;
            end
        end
        @(negedge Clk);
        assert (o_cmd_ready) else begin
            $display("Command ready did not rise at the end of the reset hold");
            errors++;
        end

        // Store tag and data, then index writeback on D and I lines
        a = 32'h1234_5608;
        send_cmd(make_instr(3'd2, 2'd1), a, {a[31:6], 6'b000010}, 32'h0);
        send_cmd(make_instr(3'd3, 2'd1), a, 32'h0, 32'hCAFE_F00D);
        send_cmd(make_instr(3'd2, 2'd0), a, {a[31:6], 6'b000011}, 32'h0);
        send_cmd(make_instr(3'd3, 2'd0), a, 32'h0, 32'h0BAD_BEEF);
        send_cmd(make_instr(3'd2, 2'd1), 32'h0000_0040, 32'h0000_0042, 32'h0);
        wait_idle();
        check_lookup(1'b1, a);
        check_lookup(1'b0, a);
        send_cmd(make_instr(3'd0, 2'd1), a, 32'h0, 32'h0);
        send_cmd(make_instr(3'd0, 2'd0), a, 32'h0, 32'h0);
        send_cmd(make_instr(3'd0, 2'd1), 32'h0000_0040, 32'h0, 32'h0);
        wait_idle();
        check_lookup(1'b1, a);
        check_lookup(1'b0, a);

        // Hit operations, illegal opcode and the bus error address
        send_cmd(make_instr(3'd2, 2'd1), 32'h7700_0014, 32'h7700_0003, 32'h0);
        send_cmd(make_instr(3'd3, 2'd1), 32'h7700_0014, 32'h0, 32'h5555_AAAA);
        send_cmd(make_instr(3'd5, 2'd1), 32'h6600_0014, 32'h0, 32'h0);
        send_cmd(make_instr(3'd4, 2'd1), 32'h6600_0014, 32'h0, 32'h0);
        send_cmd({LW_OPCODE, 26'(make_instr(3'd2, 2'd1))}, 32'h7700_0014, 32'h0, 32'h0);
        wait_idle();
        check_lookup(1'b1, 32'h7700_0014);
        send_cmd(make_instr(3'd5, 2'd1), 32'h7700_0014, 32'h0, 32'h0);
        send_cmd(make_instr(3'd2, 2'd1), ERR_ADDR, {ERR_ADDR[31:6], 6'b000011}, 32'h0);
        send_cmd(make_instr(3'd3, 2'd1), ERR_ADDR, 32'h0, 32'h1357_9BDF);
        send_cmd(make_instr(3'd5, 2'd1), ERR_ADDR, 32'h0, 32'h0);
        send_cmd(make_instr(3'd2, 2'd0), 32'h4400_0020, 32'h4400_0002, 32'h0);
        send_cmd(make_instr(3'd4, 2'd0), 32'h4400_0020, 32'h0, 32'h0);
        wait_idle();
        check_lookup(1'b1, ERR_ADDR);
        check_lookup(1'b0, 32'h4400_0020);

        // Random back-to-back traffic under back-pressure
        for (int n = 0; n < 60; n++) begin
            tag_lo = 2'(rand_bits(2));
            set_idx = 4'(rand_bits(4));
            op_idx = 3'(rand_bits(3));
            sel_bit = rand_bit();
            tag_valid = rand_bit() | rand_bit();
            tag_dirty = rand_bit();
            wdata = rand_bits(32);
            a = {24'hA50000, tag_lo, set_idx, 2'b00};
            send_cmd(make_instr(op_tbl[op_idx], {1'b0, sel_bit}), a,
                     {a[31:6], 4'b0, tag_valid, tag_dirty}, wdata);
        end
        wait_idle();
        for (int s = 0; s < SET_COUNT; s++) begin
            check_lookup(1'b0, {24'hA50000, 2'd0, 4'(s), 2'b00});
            check_lookup(1'b1, {24'hA50000, 2'd1, 4'(s), 2'b00});
        end
        assert (writes_seen == writes_expected) else begin
            $display("MISMATCH write count: got %h expected %h", writes_seen, writes_expected);
            errors++;
        end

        $display("Errors %0d, writes %0d of %0d", errors, writes_seen, writes_expected);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic Clk,
    output logic aresetn
);

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    // Reset held for two clock cycles, released on a falling edge
    initial begin
        aresetn = 1'b0;
        repeat (2) @(posedge Clk);
        @(negedge Clk);
        aresetn = 1'b1;
    end

endmodule

/* cache_maint_top.f */
verilog/cache_maint_pkg.sv
verilog/cache_maint_if.sv
verilog/reset_stretch.sv
verilog/cache_op_decode.sv
verilog/cache_tag_execute.sv
verilog/cache_result_axil.sv
verilog/cache_maint_top.sv
bench/tb_clock_gen.sv
bench/cache_maint_tb.sv

/* verilog/cache_maint_if.sv */
`timescale 1ns/1ps

// Decoded maintenance command, decode to execute
interface cache_cmd_if;
    import cache_maint_pkg::*;

    logic valid;
    logic ready;
    cache_sel_t sel;
    cache_op_t op;
    logic [INDEX_WIDTH-1:0] index;
    logic [TAG_WIDTH-1:0] tag;
    logic [TAG_WIDTH-1:0] taglo_tag;
    logic taglo_valid;
    logic taglo_dirty;
    logic [31:0] data;
    logic illegal;

    modport source (output valid, sel, op, index, tag, taglo_tag, taglo_valid, taglo_dirty,
                    output data, illegal, input ready);
    modport sink (input valid, sel, op, index, tag, taglo_tag, taglo_valid, taglo_dirty,
                  input data, illegal, output ready);
endinterface

// Completion record with optional writeback, execute to result
interface cache_wb_if;
    import cache_maint_pkg::*;

    logic valid;
    logic ready;
    logic need_write;
    logic [31:0] addr;
    logic [31:0] data;
    cmd_status_t status;

    modport source (output valid, need_write, addr, data, status, input ready);
    modport sink (input valid, need_write, addr, data, status, output ready);
endinterface

/* verilog/cache_maint_pkg.sv */
package cache_maint_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////////////////////

    localparam int OPCODE_WIDTH = 6;
    localparam int OPCODE_LSB = 26;
    localparam logic [OPCODE_WIDTH-1:0] CACHE_OPCODE = 6'b101111;
    localparam int CACHE_OP_LSB = 18;
    localparam int CACHE_SEL_LSB = 16;

    ////////////////////////////////////////////////////////////////////////////
    // Store geometry and TagLo layout
    ////////////////////////////////////////////////////////////////////////////

    localparam int SET_COUNT = 16;
    localparam int INDEX_WIDTH = 4;
    localparam int INDEX_LSB = 2;
    localparam int TAG_WIDTH = 26;
    localparam int TAG_LSB = 6;
    localparam int TAGLO_VALID_BIT = 1;
    localparam int TAGLO_DIRTY_BIT = 0;

    // Internal reset hold after aresetn release
    localparam int RESET_HOLD_CYCLES = 16;
    localparam int RESET_CNT_WIDTH = $clog2(RESET_HOLD_CYCLES);

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // Cache select, instr[17:16]
    typedef enum logic [1:0] {
        SEL_ICACHE = 2'd0,
        SEL_DCACHE = 2'd1,
        // Tertiary and secondary caches are not present
        SEL_TCACHE = 2'd2,
        SEL_SCACHE = 2'd3
    } cache_sel_t;

    // Operation, instr[20:18]
    typedef enum logic [2:0] {
        OP_INDEX_WB_INV     = 3'd0,
        OP_NOP              = 3'd1,
        OP_INDEX_STORE_TAG  = 3'd2,
        OP_INDEX_STORE_DATA = 3'd3,
        OP_HIT_INV          = 3'd4,
        OP_HIT_WB_INV       = 3'd5
    } cache_op_t;

    typedef enum logic [1:0] {
        ST_OK        = 2'd0,
        ST_WRITEBACK = 2'd1,
        ST_BUS_ERROR = 2'd2,
        ST_ILLEGAL   = 2'd3
    } cmd_status_t;

endpackage

/* verilog/cache_maint_top.sv */
`timescale 1ns/1ps

module cache_maint_top (
    input  logic                        Clk,
    input  logic                        aresetn,
    // Command port
    input  logic                        i_cmd_valid,
    output logic                        o_cmd_ready,
    input  logic [31:0]                 i_instr,
    input  logic [31:0]                 i_addr,
    input  logic [31:0]                 i_taglo,
    input  logic [31:0]                 i_data,
    // Lookup port
    input  cache_maint_pkg::cache_sel_t i_lookup_sel,
    input  logic [31:0]                 i_lookup_addr,
    output logic                        o_lookup_hit,
    output logic                        o_lookup_dirty,
    output logic [31:0]                 o_lookup_data,
    // AXI4-Lite write master
    output logic                        o_awvalid,
    output logic [31:0]                 o_awaddr,
    input  logic                        i_awready,
    output logic                        o_wvalid,
    output logic [31:0]                 o_wdata,
    input  logic                        i_wready,
    input  logic                        i_bvalid,
    input  logic [1:0]                  i_bresp,
    output logic                        o_bready,
    // Completion
    output logic                        o_done,
    output cache_maint_pkg::cmd_status_t o_status
);

    logic rst_n;

    cache_cmd_if cmd_if ();
    cache_wb_if wb_if ();

    reset_stretch u_reset_stretch (
        .i_clk   (Clk),
        .aresetn (aresetn),
        .o_rst_n (rst_n)
    );

    cache_op_decode u_cache_op_decode (
        .Clk         (Clk),
        .i_rst_n     (rst_n),
        .i_cmd_valid (i_cmd_valid),
        .i_instr     (i_instr),
        .i_addr      (i_addr),
        .i_taglo     (i_taglo),
        .i_data      (i_data),
        .o_cmd_ready (o_cmd_ready),
        .cmd         (cmd_if.source)
    );

    cache_tag_execute u_cache_tag_execute (
        .Clk            (Clk),
        .i_rst_n        (rst_n),
        .cmd            (cmd_if.sink),
        .wb             (wb_if.source),
        .i_lookup_sel   (i_lookup_sel),
        .i_lookup_addr  (i_lookup_addr),
        .o_lookup_hit   (o_lookup_hit),
        .o_lookup_dirty (o_lookup_dirty),
        .o_lookup_data  (o_lookup_data)
    );

    cache_result_axil u_cache_result_axil (
        .Clk       (Clk),
        .i_rst_n   (rst_n),
        .wb        (wb_if.sink),
        .o_awvalid (o_awvalid),
        .o_awaddr  (o_awaddr),
        .i_awready (i_awready),
        .o_wvalid  (o_wvalid),
        .o_wdata   (o_wdata),
        .i_wready  (i_wready),
        .i_bvalid  (i_bvalid),
        .i_bresp   (i_bresp),
        .o_bready  (o_bready),
        .o_done    (o_done),
        .o_status  (o_status)
    );

endmodule

/* verilog/cache_op_decode.sv */
`timescale 1ns/1ps

module cache_op_decode (
    input  logic        Clk,
    input  logic        i_rst_n,
    input  logic        i_cmd_valid,
    input  logic [31:0] i_instr,
    input  logic [31:0] i_addr,
    input  logic [31:0] i_taglo,
    input  logic [31:0] i_data,
    output logic        o_cmd_ready,
    cache_cmd_if.source cmd
);
    import cache_maint_pkg::*;

    logic accept_en;
    logic cmd_take;
    logic dec_illegal;
    cache_sel_t dec_sel;
    cache_op_t dec_op;

    assign o_cmd_ready = accept_en && (!cmd.valid || cmd.ready);
    assign cmd_take = i_cmd_valid && o_cmd_ready;

    always_comb begin
        dec_illegal = i_instr[OPCODE_LSB +: OPCODE_WIDTH] != CACHE_OPCODE;
        dec_sel = cache_sel_t'(i_instr[CACHE_SEL_LSB +: 2]);
        case (i_instr[CACHE_OP_LSB +: 3])
            3'd0: dec_op = OP_INDEX_WB_INV;
            3'd2: dec_op = OP_INDEX_STORE_TAG;
            3'd3: dec_op = OP_INDEX_STORE_DATA;
            3'd4: dec_op = OP_HIT_INV;
            3'd5: dec_op = OP_HIT_WB_INV;
            default: dec_op = OP_NOP;
        endcase
        // Hit writeback only exists on the D-cache
        if (dec_sel == SEL_ICACHE && dec_op == OP_HIT_WB_INV) begin
            dec_op = OP_NOP;
        end
        if ((dec_sel != SEL_ICACHE && dec_sel != SEL_DCACHE) || dec_illegal) begin
            dec_op = OP_NOP;
        end
    end

    always_ff @(posedge Clk) begin
        if (!i_rst_n) begin
            accept_en <= 1'b0;
            cmd.valid <= 1'b0;
        end else begin
            accept_en <= 1'b1;
            if (o_cmd_ready) begin
                cmd.valid <= i_cmd_valid;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (cmd_take) begin
            cmd.sel <= dec_sel;
            cmd.op <= dec_op;
            cmd.illegal <= dec_illegal;
            cmd.index <= i_addr[INDEX_LSB +: INDEX_WIDTH];
            cmd.tag <= i_addr[TAG_LSB +: TAG_WIDTH];
            cmd.taglo_tag <= i_taglo[TAG_LSB +: TAG_WIDTH];
            cmd.taglo_valid <= i_taglo[TAGLO_VALID_BIT];
            cmd.taglo_dirty <= i_taglo[TAGLO_DIRTY_BIT];
            cmd.data <= i_data;
        end
    end

    property p_stall_hold;
        @(posedge Clk) disable iff (!i_rst_n)
        cmd.valid && !cmd.ready |=> cmd.valid && $stable({cmd.sel, cmd.op, cmd.index,
            cmd.tag, cmd.taglo_tag, cmd.taglo_valid, cmd.taglo_dirty, cmd.data, cmd.illegal});
    endproperty
    a_stall_hold: assert property (p_stall_hold);

endmodule

/* verilog/cache_result_axil.sv */
`timescale 1ns/1ps

module cache_result_axil (
    input  logic                        Clk,
    input  logic                        i_rst_n,
    cache_wb_if.sink                    wb,
    output logic                        o_awvalid,
    output logic [31:0]                 o_awaddr,
    input  logic                        i_awready,
    output logic                        o_wvalid,
    output logic [31:0]                 o_wdata,
    input  logic                        i_wready,
    input  logic                        i_bvalid,
    input  logic [1:0]                  i_bresp,
    output logic                        o_bready,
    output logic                        o_done,
    output cache_maint_pkg::cmd_status_t o_status
);
    import cache_maint_pkg::*;

    typedef enum logic [1:0] {IDLE, ADDR_DATA, RESP, DONE} state_t;

    state_t state_q;
    logic take;
    logic aw_hs;
    logic w_hs;

    // A new record may enter while the previous completion is reported
    assign wb.ready = (state_q == IDLE) || (state_q == DONE);
    assign take = wb.valid && wb.ready;
    assign aw_hs = o_awvalid && i_awready;
    assign w_hs = o_wvalid && i_wready;
    assign o_bready = (state_q == RESP);
    assign o_done = (state_q == DONE);

    always_ff @(posedge Clk) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
            o_awvalid <= 1'b0;
            o_wvalid <= 1'b0;
        end else begin
            case (state_q)
                IDLE, DONE: begin
                    if (take && wb.need_write) begin
                        state_q <= ADDR_DATA;
                        o_awvalid <= 1'b1;
                        o_wvalid <= 1'b1;
                    end else begin
                        state_q <= take ? DONE : IDLE;
                    end
                end
                ADDR_DATA: begin
                    if (aw_hs) begin
                        o_awvalid <= 1'b0;
                    end
                    if (w_hs) begin
                        o_wvalid <= 1'b0;
                    end
                    if ((aw_hs || !o_awvalid) && (w_hs || !o_wvalid)) begin
                        state_q <= RESP;
                    end
                end
                RESP: begin
                    if (i_bvalid) begin
                        state_q <= DONE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (take) begin
            o_awaddr <= wb.addr;
            o_wdata <= wb.data;
            o_status <= wb.status;
        end else if (o_bready && i_bvalid) begin
            o_status <= (i_bresp == AXI_RESP_OKAY) ? ST_WRITEBACK : ST_BUS_ERROR;
        end
    end

    a_aw_hold: assert property (@(posedge Clk) disable iff (!i_rst_n)
        o_awvalid && !i_awready |=> o_awvalid && $stable(o_awaddr));
    a_w_hold: assert property (@(posedge Clk) disable iff (!i_rst_n)
        o_wvalid && !i_wready |=> o_wvalid && $stable(o_wdata));
    a_done_clear: assert property (@(posedge Clk) disable iff (!i_rst_n)
        o_done |-> !(o_bready || o_awvalid || o_wvalid));

endmodule

/* verilog/cache_tag_execute.sv */
`timescale 1ns/1ps

module cache_tag_execute (
    input  logic                      Clk,
    input  logic                      i_rst_n,
    cache_cmd_if.sink                 cmd,
    cache_wb_if.source                wb,
    input  cache_maint_pkg::cache_sel_t i_lookup_sel,
    input  logic [31:0]               i_lookup_addr,
    output logic                      o_lookup_hit,
    output logic                      o_lookup_dirty,
    output logic [31:0]               o_lookup_data
);
    import cache_maint_pkg::*;

    // Store 0 is the I-cache, store 1 the D-cache
    logic [TAG_WIDTH-1:0] tag_mem [2][SET_COUNT];
    logic [31:0] data_mem [2][SET_COUNT];
    logic [SET_COUNT-1:0] valid_q [2];
    logic [SET_COUNT-1:0] dirty_q [2];

    logic cmd_take;
    logic cid;
    logic cur_valid;
    logic cur_dirty;
    logic cur_hit;
    logic wr_tag;
    logic wr_data;
    logic set_dirty;
    logic clr_line;
    logic need_wb;

    logic l_cid;
    logic l_present;
    logic [INDEX_WIDTH-1:0] l_idx;
    logic l_hit;

    assign cmd.ready = !wb.valid || wb.ready;
    assign cmd_take = cmd.valid && cmd.ready;
    assign cid = (cmd.sel == SEL_DCACHE);

    ////////////////////////////////////////////////////////////////////////////
    // Operation decode against current line state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        cur_valid = valid_q[cid][cmd.index];
        cur_dirty = dirty_q[cid][cmd.index];
        cur_hit = cur_valid && (tag_mem[cid][cmd.index] == cmd.tag);
        wr_tag = 1'b0;
        wr_data = 1'b0;
        set_dirty = 1'b0;
        clr_line = 1'b0;
        need_wb = 1'b0;
        if (!cmd.illegal) begin
            case (cmd.op)
                OP_INDEX_STORE_TAG: wr_tag = 1'b1;
                OP_INDEX_STORE_DATA: begin
                    wr_data = 1'b1;
                    set_dirty = cur_valid && cid;
                end
                OP_INDEX_WB_INV: begin
                    clr_line = 1'b1;
                    need_wb = cid && cur_valid && cur_dirty;
                end
                OP_HIT_INV: clr_line = cur_hit;
                OP_HIT_WB_INV: begin
                    clr_line = cur_hit;
                    need_wb = cur_hit && cur_dirty;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (cmd_take && wr_tag) begin
            tag_mem[cid][cmd.index] <= cmd.taglo_tag;
        end
        if (cmd_take && wr_data) begin
            data_mem[cid][cmd.index] <= cmd.data;
        end
    end

    always_ff @(posedge Clk) begin
        if (!i_rst_n) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
        end else if (cmd_take) begin
            if (wr_tag) begin
                valid_q[cid][cmd.index] <= cmd.taglo_valid;
                dirty_q[cid][cmd.index] <= cid && cmd.taglo_dirty;
            end
            if (set_dirty) begin
                dirty_q[cid][cmd.index] <= 1'b1;
            end
            if (clr_line) begin
                valid_q[cid][cmd.index] <= 1'b0;
                dirty_q[cid][cmd.index] <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Completion record towards the result stage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (!i_rst_n) begin
            wb.valid <= 1'b0;
        end else if (cmd.ready) begin
            wb.valid <= cmd.valid;
        end
    end

    always_ff @(posedge Clk) begin
        if (cmd_take) begin
            wb.need_write <= need_wb;
            wb.addr <= {tag_mem[cid][cmd.index], cmd.index, {INDEX_LSB{1'b0}}};
            wb.data <= data_mem[cid][cmd.index];
            wb.status <= cmd.illegal ? ST_ILLEGAL : ST_OK;
        end
    end

    // Lookup sees the stores as left by every command past execute
    assign l_cid = (i_lookup_sel == SEL_DCACHE);
    assign l_present = (i_lookup_sel == SEL_ICACHE) || (i_lookup_sel == SEL_DCACHE);
    assign l_idx = i_lookup_addr[INDEX_LSB +: INDEX_WIDTH];
    assign l_hit = l_present && valid_q[l_cid][l_idx]
                   && (tag_mem[l_cid][l_idx] == i_lookup_addr[TAG_LSB +: TAG_WIDTH]);
    assign o_lookup_hit = l_hit;
    assign o_lookup_dirty = l_hit && dirty_q[l_cid][l_idx];
    assign o_lookup_data = data_mem[l_cid][l_idx];

    property p_no_icache_write;
        @(posedge Clk) disable iff (!i_rst_n)
        cmd_take && cmd.sel != SEL_DCACHE |=> !(wb.valid && wb.need_write);
    endproperty
    a_no_icache_write: assert property (p_no_icache_write);

endmodule

/* verilog/reset_stretch.sv */
`timescale 1ns/1ps

module reset_stretch (
    input  logic i_clk,
    input  logic aresetn,
    output logic o_rst_n
);
    import cache_maint_pkg::*;

    logic [RESET_CNT_WIDTH-1:0] hold_cnt;

    // Count only while the internal reset is still held
    always_ff @(posedge i_clk) begin
        if (!aresetn) begin
            hold_cnt <= '0;
            o_rst_n <= 1'b0;
        end else if (!o_rst_n) begin
            hold_cnt <= hold_cnt + 1'b1;
            if (hold_cnt == RESET_CNT_WIDTH'(RESET_HOLD_CYCLES - 1)) begin
                o_rst_n <= 1'b1;
            end
        end
    end

    property p_hold_release;
        @(posedge i_clk) $rose(aresetn) |-> !o_rst_n [*RESET_HOLD_CYCLES];
    endproperty
    a_hold_release: assert property (p_hold_release);

endmodule
